/* hdl/cnn_quad_pkg.sv */
`default_nettype none

package cnn_quad_pkg;

    ////////////////////////////////////////
    // Widths and lane count
    ////////////////////////////////////////
    localparam int NUM_LANES       = 4;
    localparam int PIXEL_WIDTH     = 8;
    localparam int WEIGHT_WIDTH    = 8;
    localparam int RESULT_WIDTH    = 16;
    localparam int ROW_COUNT_WIDTH = 8;

    ////////////////////////////////////////
    // Lane data types
    ////////////////////////////////////////
    typedef logic signed [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [RESULT_WIDTH-1:0] result_t;

    typedef pixel_t  [NUM_LANES-1:0] pixel_word_t;
    typedef weight_t [NUM_LANES-1:0] weight_word_t;
    typedef result_t [NUM_LANES-1:0] result_word_t;

    // Job descriptor as seen on job_parameters
    typedef struct packed {
        logic [ROW_COUNT_WIDTH-1:0] row_count;
        logic                       relu_en;
        logic [6:0]                 reserved;
    } job_params_t;

    // Prefetch buffer entry
    typedef struct packed {
        logic        last;
        pixel_word_t data;
    } pixel_beat_t;

endpackage

`default_nettype wire

/* hdl/lane_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lane_ctrl_if;

    // Job state from the controller
    logic job_active;
    logic relu_en;

    // Status back from the lane engine
    logic weights_loaded;
    logic job_done;

    modport ctrl (
        output job_active,
        output relu_en,
        input  weights_loaded,
        input  job_done
    );

    modport engine (
        input  job_active,
        input  relu_en,
        output weights_loaded,
        output job_done
    );

endinterface

`default_nettype wire

/* hdl/cnn_job_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_job_ctrl
    import cnn_quad_pkg::*;
(
    input  logic        clk_core,
    input  logic        rst,
    input  logic        job_start,
    output logic        job_accept,
    input  job_params_t job_parameters,
    output logic        job_fetch_request,
    input  logic        job_fetch_ack,
    output logic        job_complete,
    input  logic        job_complete_ack,
    input  logic        pixel_valid,
    output logic        pixel_ready,
    input  pixel_word_t pixel_data,
    output logic        fifo_wr_en,
    output pixel_beat_t fifo_din,
    input  logic        fifo_full,
    lane_ctrl_if.ctrl   ctrl
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_FETCH,
        ST_WAIT_DONE,
        ST_COMPLETE
    } state_t;

    state_t                     state;
    job_params_t                params_q;
    logic [ROW_COUNT_WIDTH-1:0] row_cnt;
    logic                       last_row;
    logic                       pixel_take;

    ////////////////////////////////////////
    // Pixel intake into the prefetch buffer
    ////////////////////////////////////////
    assign pixel_ready = (state == ST_FETCH) && !fifo_full;
    assign pixel_take  = pixel_valid && pixel_ready;
    assign last_row    = (row_cnt == ROW_COUNT_WIDTH'(params_q.row_count - 1'b1));

    assign fifo_wr_en = pixel_take;
    assign fifo_din   = '{last: last_row, data: pixel_data};

    // Engine sees the job as active from accept until complete is acked
    assign ctrl.job_active = (state != ST_IDLE);
    assign ctrl.relu_en    = params_q.relu_en;

    ////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            state             <= ST_IDLE;
            params_q          <= '0;
            row_cnt           <= '0;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
        end else begin
            job_accept <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start && ctrl.weights_loaded) begin
                        job_accept <= 1'b1;
                        params_q   <= job_parameters;
                        row_cnt    <= '0;
                        // Empty job skips the fetch phase
                        if (job_parameters.row_count == '0) begin
                            state <= ST_COMPLETE;
                        end else begin
                            state <= ST_REQUEST;
                        end
                    end
                end
                ST_REQUEST: begin
                    if (!job_fetch_request) begin
                        job_fetch_request <= 1'b1;
                    end else if (job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        state             <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (pixel_take) begin
                        row_cnt <= row_cnt + 1'b1;
                        if (last_row) begin
                            state <= ST_WAIT_DONE;
                        end else begin
                            // Next request goes up right after the take
                            job_fetch_request <= 1'b1;
                            state             <= ST_REQUEST;
                        end
                    end
                end
                ST_WAIT_DONE: begin
                    if (ctrl.job_done) begin
                        job_complete <= 1'b1;
                        state        <= ST_COMPLETE;
                    end
                end
                ST_COMPLETE: begin
                    if (!job_complete) begin
                        job_complete <= 1'b1;
                    end else if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/prefetch_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module prefetch_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 8
) (
    input  logic clk_core,
    input  logic rst,
    input  logic wr_en,
    input  T     din,
    output logic full,
    input  logic rd_en,
    output T     dout,
    output logic empty
);

    localparam int AW = $clog2(DEPTH);

    T             mem [DEPTH];
    logic [AW:0]  wr_ptr;
    logic [AW:0]  rd_ptr;
    logic         do_write;
    logic         do_read;

    // Extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // Head entry shown directly
    assign dout = mem[rd_ptr[AW-1:0]];

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= din;
        end
    end

    ////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cnn_lane_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_lane_engine
    import cnn_quad_pkg::*;
(
    input  logic         clk_core,
    input  logic         rst,
    input  logic         weight_valid,
    output logic         weight_ready,
    input  weight_word_t weight_data,
    output logic         fifo_rd_en,
    input  pixel_beat_t  fifo_dout,
    input  logic         fifo_empty,
    output logic         result_valid,
    input  logic         result_accept,
    output result_word_t result_data,
    lane_ctrl_if.engine  eng
);

    weight_word_t weights_q;
    logic         weights_loaded_q;
    logic         weight_load;
    pixel_word_t  relu_px;
    result_word_t prod;
    logic         result_last;

    ////////////////////////////////////////
    // Weight register
    ////////////////////////////////////////
    // Weights only change between jobs
    assign weight_ready = weight_valid && !eng.job_active;
    assign weight_load  = weight_valid && weight_ready;

    assign eng.weights_loaded = weights_loaded_q;

    always_ff @(posedge clk_core) begin
        if (weight_load) begin
            weights_q <= weight_data;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            weights_loaded_q <= 1'b0;
        end else if (weight_load) begin
            weights_loaded_q <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // ReLU and lane multiplies
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            // Negative pixel clamps to zero
            if (eng.relu_en && fifo_dout.data[i][PIXEL_WIDTH-1]) begin
                relu_px[i] = '0;
            end else begin
                relu_px[i] = fifo_dout.data[i];
            end
            prod[i] = result_t'(relu_px[i]) * result_t'(weights_q[i]);
        end
    end

    ////////////////////////////////////////
    // Result register
    ////////////////////////////////////////
    // Pop when the output slot is free or draining this cycle
    assign fifo_rd_en = !fifo_empty && (!result_valid || result_accept);

    always_ff @(posedge clk_core) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (fifo_rd_en) begin
            result_valid <= 1'b1;
        end else if (result_accept) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_core) begin
        if (fifo_rd_en) begin
            result_data <= prod;
            result_last <= fifo_dout.last;
        end
    end

    // Final row leaving the quad ends the job
    assign eng.job_done = result_valid && result_accept && result_last;

endmodule

`default_nettype wire

/* hdl/cnn_quad_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_quad_top
    import cnn_quad_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                              clk_core,
    input  logic                              rst,
    input  logic                              job_start,
    output logic                              job_accept,
    input  logic [$bits(job_params_t)-1:0]    job_parameters,
    output logic                              job_fetch_request,
    input  logic                              job_fetch_ack,
    output logic                              job_complete,
    input  logic                              job_complete_ack,
    input  logic                              pixel_valid,
    output logic                              pixel_ready,
    input  logic [$bits(pixel_word_t)-1:0]    pixel_data,
    input  logic                              weight_valid,
    output logic                              weight_ready,
    input  logic [$bits(weight_word_t)-1:0]   weight_data,
    output logic                              result_valid,
    input  logic                              result_accept,
    output logic [$bits(result_word_t)-1:0]   result_data
);

    logic        fifo_wr_en;
    pixel_beat_t fifo_din;
    logic        fifo_full;
    logic        fifo_rd_en;
    pixel_beat_t fifo_dout;
    logic        fifo_empty;

    lane_ctrl_if lane_ctrl ();

    ////////////////////////////////////////
    // Producer, buffer, consumer
    ////////////////////////////////////////
    cnn_job_ctrl u_job_ctrl (
        .clk_core          (clk_core),
        .rst               (rst),
        .job_start         (job_start),
        .job_accept        (job_accept),
        .job_parameters    (job_parameters),
        .job_fetch_request (job_fetch_request),
        .job_fetch_ack     (job_fetch_ack),
        .job_complete      (job_complete),
        .job_complete_ack  (job_complete_ack),
        .pixel_valid       (pixel_valid),
        .pixel_ready       (pixel_ready),
        .pixel_data        (pixel_data),
        .fifo_wr_en        (fifo_wr_en),
        .fifo_din          (fifo_din),
        .fifo_full         (fifo_full),
        .ctrl              (lane_ctrl.ctrl)
    );

    prefetch_fifo #(
        .T     (pixel_beat_t),
        .DEPTH (FIFO_DEPTH)
    ) u_prefetch_fifo (
        .clk_core (clk_core),
        .rst      (rst),
        .wr_en    (fifo_wr_en),
        .din      (fifo_din),
        .full     (fifo_full),
        .rd_en    (fifo_rd_en),
        .dout     (fifo_dout),
        .empty    (fifo_empty)
    );

    cnn_lane_engine u_lane_engine (
        .clk_core      (clk_core),
        .rst           (rst),
        .weight_valid  (weight_valid),
        .weight_ready  (weight_ready),
        .weight_data   (weight_data),
        .fifo_rd_en    (fifo_rd_en),
        .fifo_dout     (fifo_dout),
        .fifo_empty    (fifo_empty),
        .result_valid  (result_valid),
        .result_accept (result_accept),
        .result_data   (result_data),
        .eng           (lane_ctrl.engine)
    );

endmodule

`default_nettype wire

/* tb/cnn_quad_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_quad_properties (
    input wire logic        clk_core,
    input wire logic        rst,
    input wire logic        job_accept,
    input wire logic        job_fetch_request,
    input wire logic        job_complete,
    input wire logic        pixel_ready,
    input wire logic        weight_ready,
    input wire logic        result_valid,
    input wire logic        result_accept,
    input wire logic [63:0] result_data
);

    // Accept is a single-cycle pulse
    a_accept_pulse : assert property (@(posedge clk_core) disable iff (rst)
        job_accept |=> !job_accept)
        else $error("job_accept held longer than one cycle");

    // Stalled result must not change
    a_result_hold : assert property (@(posedge clk_core) disable iff (rst)
        result_valid && !result_accept |=> result_valid && $stable(result_data))
        else $error("result_data changed while the result was stalled");

    a_ready_in_reset : assert property (@(posedge clk_core)
        rst && $past(rst) |-> !pixel_ready)
        else $error("pixel_ready high during reset");

    a_weight_idle_only : assert property (@(posedge clk_core) disable iff (rst)
        job_complete || job_fetch_request |-> !weight_ready)
        else $error("weight_ready high while a job is running");

endmodule

bind cnn_quad_top cnn_quad_properties u_properties (
    .clk_core          (clk_core),
    .rst               (rst),
    .job_accept        (job_accept),
    .job_fetch_request (job_fetch_request),
    .job_complete      (job_complete),
    .pixel_ready       (pixel_ready),
    .weight_ready      (weight_ready),
    .result_valid      (result_valid),
    .result_accept     (result_accept),
    .result_data       (result_data)
);

`default_nettype wire

/* tb/cnn_quad_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_quad_tb
    import cnn_quad_pkg::*;
();

    localparam int WAIT_LIMIT   = 200;
    localparam int RESULT_LIMIT = 1000;

    logic                            clk_core;
    logic                            rst;
    logic                            job_start;
    logic                            job_accept;
    logic [$bits(job_params_t)-1:0]  job_parameters;
    logic                            job_fetch_request;
    logic                            job_fetch_ack;
    logic                            job_complete;
    logic                            job_complete_ack;
    logic                            pixel_valid;
    logic                            pixel_ready;
    logic [$bits(pixel_word_t)-1:0]  pixel_data;
    logic                            weight_valid;
    logic                            weight_ready;
    logic [$bits(weight_word_t)-1:0] weight_data;
    logic                            result_valid;
    logic                            result_accept;
    logic [$bits(result_word_t)-1:0] result_data;

    // Reference model state
    weight_word_t cur_weights;
    pixel_word_t  px_q[$];
    result_word_t exp_q[$];
    logic         ready_dropped;
    int           value_errors;
    int           timeouts;

    cnn_quad_top #(
        .FIFO_DEPTH (8)
    ) uut (
        .clk_core          (clk_core),
        .rst               (rst),
        .job_start         (job_start),
        .job_accept        (job_accept),
        .job_parameters    (job_parameters),
        .job_fetch_request (job_fetch_request),
        .job_fetch_ack     (job_fetch_ack),
        .job_complete      (job_complete),
        .job_complete_ack  (job_complete_ack),
        .pixel_valid       (pixel_valid),
        .pixel_ready       (pixel_ready),
        .pixel_data        (pixel_data),
        .weight_valid      (weight_valid),
        .weight_ready      (weight_ready),
        .weight_data       (weight_data),
        .result_valid      (result_valid),
        .result_accept     (result_accept),
        .result_data       (result_data)
    );

    initial begin
        clk_core = 1'b0;
        forever #2 clk_core = ~clk_core;
    end

    ////////////////////////////////////////
    // Compare tasks and reference model
    ////////////////////////////////////////
    task automatic check_result(input result_word_t got, input result_word_t exp,
                                input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_params(input job_params_t got, input job_params_t exp,
                                input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out at %0t ns waiting for %s", $time, what);
    endtask

    // Lane product with optional clamp of negative pixels
    function automatic result_word_t lane_products(input pixel_word_t px,
                                                   input weight_word_t w, input logic relu);
        result_word_t r;
        int           p;
        for (int i = 0; i < NUM_LANES; i++) begin
            p = int'(px[i]);
            if (relu && p < 0) begin
                p = 0;
            end
            r[i] = result_t'(p * int'(w[i]));
        end
        return r;
    endfunction

    task automatic make_pixels(input int rows);
        px_q.delete();
        repeat (rows) px_q.push_back(pixel_word_t'($urandom));
    endtask

    ////////////////////////////////////////
    // Drivers and responders
    ////////////////////////////////////////
    // All of these start and end on a falling edge
    task automatic load_weights(input weight_word_t w);
        int cyc;
        weight_valid = 1'b1;
        weight_data  = w;
        #1;
        cyc = 0;
        while (!weight_ready && cyc < WAIT_LIMIT) begin
            @(negedge clk_core);
            #1;
            cyc++;
        end
        if (!weight_ready) begin
            report_timeout("weight_ready");
        end else begin
            cur_weights = w;
        end
        @(negedge clk_core);
        weight_valid = 1'b0;
    endtask

    task automatic start_job(input job_params_t p, input int limit, output logic accepted);
        int cyc;
        job_start      = 1'b1;
        job_parameters = p;
        cyc = 0;
        while (!job_accept && cyc < limit) begin
            @(negedge clk_core);
            cyc++;
        end
        accepted       = job_accept;
        job_start      = 1'b0;
        job_parameters = '0;
    endtask

    task automatic feed_rows();
        int cyc;
        foreach (px_q[r]) begin
            cyc = 0;
            while (!job_fetch_request && cyc < WAIT_LIMIT) begin
                @(negedge clk_core);
                cyc++;
            end
            if (!job_fetch_request) begin
                report_timeout("job_fetch_request");
                return;
            end
            job_fetch_ack = 1'b1;
            @(negedge clk_core);
            job_fetch_ack = 1'b0;
            pixel_valid   = 1'b1;
            pixel_data    = px_q[r];
            cyc = 0;
            while (!pixel_ready && cyc < RESULT_LIMIT) begin
                ready_dropped = 1'b1;
                @(negedge clk_core);
                cyc++;
            end
            if (!pixel_ready) begin
                report_timeout("pixel_ready");
                pixel_valid = 1'b0;
                return;
            end
            @(negedge clk_core);
            pixel_valid = 1'b0;
        end
    endtask

    // Accept is held low for hold cycles, then high pct percent of the time
    task automatic collect_results(input int hold, input int pct);
        int cyc;
        int n_seen;
        n_seen = 0;
        cyc    = 0;
        while (n_seen < px_q.size() && cyc < RESULT_LIMIT) begin
            if (cyc < hold) begin
                result_accept = 1'b0;
            end else begin
                result_accept = ($urandom_range(99) < pct);
            end
            if (result_valid && result_accept) begin
                check_result(result_word_t'(result_data), exp_q.pop_front(),
                             $sformatf("result row %0d", n_seen));
                n_seen++;
            end
            @(negedge clk_core);
            cyc++;
        end
        result_accept = 1'b0;
        if (n_seen < px_q.size()) begin
            report_timeout("result_valid");
        end
    endtask

    task automatic finish_job();
        int cyc;
        cyc = 0;
        while (!job_complete && cyc < WAIT_LIMIT) begin
            @(negedge clk_core);
            cyc++;
        end
        if (!job_complete) begin
            report_timeout("job_complete");
            return;
        end
        job_complete_ack = 1'b1;
        @(negedge clk_core);
        job_complete_ack = 1'b0;
        check_flag(job_complete, 1'b0, "job_complete after ack");
    endtask

    task automatic run_job(input logic relu, input int hold, input int pct, input logic probe);
        job_params_t p;
        logic        accepted;
        int          cyc;
        exp_q.delete();
        foreach (px_q[r]) exp_q.push_back(lane_products(px_q[r], cur_weights, relu));
        p.row_count = ROW_COUNT_WIDTH'(px_q.size());
        p.relu_en   = relu;
        p.reserved  = 7'h55;
        start_job(p, WAIT_LIMIT, accepted);
        if (!accepted) begin
            report_timeout("job_accept");
            return;
        end
        check_params(uut.u_job_ctrl.params_q, p, "captured job parameters");
        // Weight load attempt must be refused mid-job
        // Held until a clock edge with the fetch request up
        if (probe) begin
            weight_valid = 1'b1;
            weight_data  = ~cur_weights;
            #1;
            check_flag(weight_ready, 1'b0, "weight_ready during active job");
            cyc = 0;
            while (!job_fetch_request && cyc < WAIT_LIMIT) begin
                @(negedge clk_core);
                #1;
                check_flag(weight_ready, 1'b0, "weight_ready during active job");
                cyc++;
            end
            if (!job_fetch_request) begin
                report_timeout("job_fetch_request");
            end
            @(negedge clk_core);
            weight_valid = 1'b0;
        end
        fork
            feed_rows();
            collect_results(hold, pct);
        join
        finish_job();
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic idle_after_reset();
        job_params_t p;
        logic        accepted;
        $display("Checking idle outputs and job refusal without weights");
        check_flag(job_accept, 1'b0, "job_accept after reset");
        check_flag(job_fetch_request, 1'b0, "job_fetch_request after reset");
        check_flag(job_complete, 1'b0, "job_complete after reset");
        check_flag(pixel_ready, 1'b0, "pixel_ready after reset");
        check_flag(weight_ready, 1'b0, "weight_ready after reset");
        check_flag(result_valid, 1'b0, "result_valid after reset");
        p = '0;
        p.row_count = 8'd2;
        start_job(p, 20, accepted);
        check_flag(accepted, 1'b0, "job accepted before weight load");
    endtask

    task automatic plain_job();
        $display("Four-row job without ReLU");
        make_pixels(4);
        px_q[0][0] = -8'sd100;
        run_job(1'b0, 0, 70, 1'b0);
    endtask

    task automatic relu_job();
        $display("Same rows with ReLU");
        run_job(1'b1, 0, 70, 1'b0);
    endtask

    task automatic backpressure_job();
        $display("Twelve rows under result back-pressure");
        make_pixels(12);
        ready_dropped = 1'b0;
        run_job(1'b0, 60, 25, 1'b0);
        check_flag(ready_dropped, 1'b1, "pixel_ready drop while results held");
    endtask

    task automatic empty_job();
        job_params_t p;
        logic        accepted;
        int          cyc;
        $display("Job with zero rows");
        px_q.delete();
        p = '0;
        start_job(p, WAIT_LIMIT, accepted);
        if (!accepted) begin
            report_timeout("job_accept");
            return;
        end
        cyc = 0;
        while (!job_complete && cyc < WAIT_LIMIT) begin
            check_flag(job_fetch_request, 1'b0, "fetch request on empty job");
            check_flag(result_valid, 1'b0, "result on empty job");
            @(negedge clk_core);
            cyc++;
        end
        finish_job();
    endtask

    task automatic weight_reload();
        $display("Weight reload between jobs");
        make_pixels(5);
        run_job(1'b0, 0, 60, 1'b1);
        load_weights(~cur_weights);
        run_job(1'b0, 0, 60, 1'b0);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(45));
        rst              = 1'b1;
        job_start        = 1'b0;
        job_parameters   = '0;
        job_fetch_ack    = 1'b0;
        job_complete_ack = 1'b0;
        pixel_valid      = 1'b0;
        pixel_data       = '0;
        weight_valid     = 1'b0;
        weight_data      = '0;
        result_accept    = 1'b0;
        cur_weights      = '0;
        ready_dropped    = 1'b0;
        value_errors     = 0;
        timeouts         = 0;
        repeat (10) @(negedge clk_core);
        rst = 1'b0;
        @(negedge clk_core);

        idle_after_reset();
        load_weights(weight_word_t'($urandom));
        plain_job();
        relu_job();
        backpressure_job();
        empty_job();
        weight_reload();

        repeat (5) @(negedge clk_core);
        $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cnn_quad.f */
hdl/cnn_quad_pkg.sv
hdl/lane_ctrl_if.sv
hdl/cnn_job_ctrl.sv
hdl/prefetch_fifo.sv
hdl/cnn_lane_engine.sv
hdl/cnn_quad_top.sv
tb/cnn_quad_properties.sv
tb/cnn_quad_tb.sv

/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = cnn_quad_tb
FILELIST = cnn_quad.f
BUILD    = obj_dir
SIM_BIN  = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
